/* design/modulation_pkg.sv */
package modulation_pkg;

    // fft output stream
    localparam int fft_w = 29;
    localparam int index_w = 12;

    // full bin power, sum of two squares
    localparam int power_w = 60;

    // buffered slice of the power, bits 59 down to 28
    localparam int stored_w = 32;
    localparam int stored_lsb = power_w - stored_w;

    // lower half of the 4096-point frame is kept
    localparam int bin_count = 2048;
    localparam int addr_w = 11;

    // centre bin shifts for the threshold tests
    localparam int cw_shift = 11;
    localparam int am_shift = 8;

    // votes per decision and counter width
    localparam int frames_per_decision = 10;
    localparam int tally_w = 4;

    // modulation codes, also driven on the leds
    localparam int mod_w = 2;
    localparam logic [mod_w-1:0] mod_unknown = 2'd0;
    localparam logic [mod_w-1:0] mod_cw = 2'd1;
    localparam logic [mod_w-1:0] mod_am = 2'd2;
    localparam logic [mod_w-1:0] mod_fm = 2'd3;

    // display digits for each code
    localparam logic [3:0] digit_unknown = 4'h0;
    localparam logic [3:0] digit_cw = 4'hC;
    localparam logic [3:0] digit_am = 4'hA;
    localparam logic [3:0] digit_fm = 4'hF;

    // capture fsm encoding
    localparam int cap_state_w = 2;
    localparam logic [cap_state_w-1:0] cap_idle = 2'd0;
    localparam logic [cap_state_w-1:0] cap_collect = 2'd1;
    localparam logic [cap_state_w-1:0] cap_read = 2'd2;
    localparam logic [cap_state_w-1:0] cap_report = 2'd3;

    // seven segment display, active low, bit 7 is the dot
    localparam int digit_count = 4;
    localparam logic [7:0] seg_patterns [16] = '{
        8'hC0, 8'hF9, 8'hA4, 8'hB0,
        8'h99, 8'h92, 8'h82, 8'hF8,
        8'h80, 8'h90, 8'h88, 8'h83,
        8'hC6, 8'hA1, 8'h86, 8'h8E
    };

endpackage

/* design/power_calc.sv */
`timescale 1ns/10ps

module power_calc import modulation_pkg::*; (
    input  logic                      clk_64m,
    input  logic                      rst,
    input  logic signed [fft_w-1:0]   fft_real,
    input  logic signed [fft_w-1:0]   fft_imag,
    input  logic        [index_w-1:0] fft_index,
    output logic        [power_w-1:0] power,
    output logic        [index_w-1:0] power_index
);

    // squares are never negative, sign extension is harmless
    logic signed [2*fft_w-1:0] real_sq;
    logic signed [2*fft_w-1:0] imag_sq;

    always_comb begin
        real_sq = fft_real * fft_real;
        imag_sq = fft_imag * fft_imag;
    end

    // power register, one cycle behind the stream
    always_ff @(posedge clk_64m) begin
        power <= power_w'(real_sq) + power_w'(imag_sq);
    end

    // index follows the power through the same stage
    always_ff @(posedge clk_64m) begin
        if (rst) begin
            power_index <= '0;
        end else begin
            power_index <= fft_index;
        end
    end

endmodule

/* design/spectrum_capture.sv */
`timescale 1ns/10ps

module spectrum_capture import modulation_pkg::*; (
    input  logic                clk_64m,
    input  logic                rst,
    input  logic [power_w-1:0]  power,
    input  logic [index_w-1:0]  power_index,
    output logic [stored_w-1:0] centre_bin,
    output logic [stored_w-1:0] side_bin,
    output logic                bins_valid
);

    // one frame of stored power slices
    logic [stored_w-1:0] bin_buf [bin_count];

    logic [cap_state_w-1:0] state;
    logic [1:0]             read_step;
    logic                   frame_start;
    logic                   accept;
    logic                   last_bin;
    logic [power_w-1:0]     peak_power;
    logic [addr_w-1:0]      peak_idx;
    logic [addr_w-1:0]      rd_addr;
    logic [stored_w-1:0]    rd_data;

    // index 0 opens a frame, also restarts one that is in progress
    assign frame_start = (state == cap_idle || state == cap_collect) && power_index == '0;

    // upper half of the spectrum is never stored
    assign accept = frame_start ||
                    (state == cap_collect && power_index < index_w'(bin_count));
    assign last_bin = state == cap_collect && power_index == index_w'(bin_count - 1);

    // step 0 peak, 1 peak minus one, 2 peak minus two
    // address wraps around the buffer
    assign rd_addr = peak_idx - addr_w'(read_step);

    always_ff @(posedge clk_64m) begin
        if (rst) begin
            state <= cap_idle;
            read_step <= '0;
        end else begin
            case (state)
                cap_idle: begin
                    if (frame_start) begin
                        state <= cap_collect;
                    end
                end
                cap_collect: begin
                    if (last_bin) begin
                        state <= cap_read;
                        read_step <= '0;
                    end
                end
                cap_read: begin
                    read_step <= read_step + 2'd1;
                    if (read_step == 2'd2) begin
                        state <= cap_report;
                    end
                end
                default: begin
                    // report lasts one cycle
                    state <= cap_idle;
                    read_step <= '0;
                end
            endcase
        end
    end

    // buffer write port
    always_ff @(posedge clk_64m) begin
        if (accept) begin
            bin_buf[power_index[addr_w-1:0]] <= power[power_w-1:stored_lsb];
        end
    end

    // peak search on the full power, strict compare keeps the earlier bin
    always_ff @(posedge clk_64m) begin
        if (frame_start) begin
            peak_power <= power;
            peak_idx <= '0;
        end else if (accept && power > peak_power) begin
            peak_power <= power;
            peak_idx <= power_index[addr_w-1:0];
        end
    end

    // registered read port, only active while reading
    always_ff @(posedge clk_64m) begin
        if (state == cap_read) begin
            rd_data <= bin_buf[rd_addr];
        end
    end

    // peak word sits in rd_data during step 1
    always_ff @(posedge clk_64m) begin
        if (state == cap_read && read_step == 2'd1) begin
            centre_bin <= rd_data;
        end
    end

    // last read holds peak minus two
    assign side_bin = rd_data;
    assign bins_valid = state == cap_report;

endmodule

/* design/modulation_vote.sv */
`timescale 1ns/10ps

module modulation_vote import modulation_pkg::*; (
    input  logic                clk_64m,
    input  logic                rst,
    input  logic [stored_w-1:0] centre_bin,
    input  logic [stored_w-1:0] side_bin,
    input  logic                bins_valid,
    output logic [mod_w-1:0]    mod_type
);

    logic               cw_hit;
    logic               am_hit;
    logic               last_vote;
    logic               decide;
    logic [tally_w-1:0] cw_count;
    logic [tally_w-1:0] am_count;
    logic [tally_w-1:0] fm_count;
    logic [tally_w-1:0] frame_cnt;
    logic [mod_w-1:0]   majority;

    // narrow carrier, side bin far below the peak
    assign cw_hit = (centre_bin >> cw_shift) > side_bin;
    // sidebands present but still well below the carrier
    assign am_hit = (centre_bin >> am_shift) > side_bin;

    assign last_vote = bins_valid &&
                       frame_cnt == tally_w'(frames_per_decision - 1);

    // frame counter
    always_ff @(posedge clk_64m) begin
        if (rst) begin
            frame_cnt <= '0;
        end else if (last_vote) begin
            frame_cnt <= '0;
        end else if (bins_valid) begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    // decision follows the tenth vote by one cycle
    always_ff @(posedge clk_64m) begin
        if (rst) begin
            decide <= 1'b0;
        end else begin
            decide <= last_vote;
        end
    end

    // tallies, one vote per frame
    always_ff @(posedge clk_64m) begin
        if (rst) begin
            cw_count <= '0;
            am_count <= '0;
            fm_count <= '0;
        end else if (decide) begin
            // fresh start for the next group
            cw_count <= '0;
            am_count <= '0;
            fm_count <= '0;
        end else if (bins_valid) begin
            if (cw_hit) begin
                cw_count <= cw_count + 1'b1;
            end else if (am_hit) begin
                am_count <= am_count + 1'b1;
            end else begin
                fm_count <= fm_count + 1'b1;
            end
        end
    end

    // majority, ties fall towards fm
    always_comb begin
        if (cw_count > am_count) begin
            majority = (cw_count > fm_count) ? mod_cw : mod_fm;
        end else begin
            majority = (am_count > fm_count) ? mod_am : mod_fm;
        end
    end

    always_ff @(posedge clk_64m) begin
        if (rst) begin
            mod_type <= mod_unknown;
        end else if (decide) begin
            mod_type <= majority;
        end
    end

endmodule

/* design/seg7_scan.sv */
`timescale 1ns/10ps

module seg7_scan import modulation_pkg::*; (
    input  logic                   clk_64m,
    input  logic                   rst,
    input  logic [3:0]             digit,
    output logic [digit_count-1:0] seg_s,
    output logic [7:0]             seg_ap
);

    // selected digit position
    logic [$clog2(digit_count)-1:0] scan_cnt;

    // free-running scan, one position per clock
    always_ff @(posedge clk_64m) begin
        if (rst) begin
            scan_cnt <= '0;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // digit enables are active low
    always_comb begin
        seg_s = '1;
        seg_s[scan_cnt] = 1'b0;
    end

    // same code on every position
    assign seg_ap = seg_patterns[digit];

endmodule

/* design/modulation_id_top.sv */
`timescale 1ns/10ps

module modulation_id_top import modulation_pkg::*; (
    input  logic                      clk_64m,
    input  logic                      rst,
    input  logic signed [fft_w-1:0]   fft_real,
    input  logic signed [fft_w-1:0]   fft_imag,
    input  logic        [index_w-1:0] fft_index,
    output logic        [mod_w-1:0]   mod_led,
    output logic [digit_count-1:0]    seg_s,
    output logic [7:0]                seg_ap
);

    logic [power_w-1:0]  power;
    logic [index_w-1:0]  power_index;
    logic [stored_w-1:0] centre_bin;
    logic [stored_w-1:0] side_bin;
    logic                bins_valid;
    logic [mod_w-1:0]    mod_type;
    logic [3:0]          disp_digit;

    // bin power from the fft stream
    power_calc power_calc_inst (
        .clk_64m     (clk_64m),
        .rst         (rst),
        .fft_real    (fft_real),
        .fft_imag    (fft_imag),
        .fft_index   (fft_index),
        .power       (power),
        .power_index (power_index)
    );

    // frame buffer and peak neighbourhood
    spectrum_capture spectrum_capture_inst (
        .clk_64m     (clk_64m),
        .rst         (rst),
        .power       (power),
        .power_index (power_index),
        .centre_bin  (centre_bin),
        .side_bin    (side_bin),
        .bins_valid  (bins_valid)
    );

    // per-frame vote and ten-frame majority
    modulation_vote modulation_vote_inst (
        .clk_64m    (clk_64m),
        .rst        (rst),
        .centre_bin (centre_bin),
        .side_bin   (side_bin),
        .bins_valid (bins_valid),
        .mod_type   (mod_type)
    );

    assign mod_led = mod_type;

    // C, A or F on the display, 0 while unknown
    always_comb begin
        case (mod_type)
            mod_cw:  disp_digit = digit_cw;
            mod_am:  disp_digit = digit_am;
            mod_fm:  disp_digit = digit_fm;
            default: disp_digit = digit_unknown;
        endcase
    end

    seg7_scan seg7_scan_inst (
        .clk_64m (clk_64m),
        .rst     (rst),
        .digit   (disp_digit),
        .seg_s   (seg_s),
        .seg_ap  (seg_ap)
    );

endmodule

/* verification/modulation_id_sva.sv */
`timescale 1ns/10ps

module modulation_id_sva import modulation_pkg::*; (
    input logic                   clk_64m,
    input logic                   rst,
    input logic [digit_count-1:0] seg_s,
    input logic                   bins_valid,
    input logic [mod_w-1:0]       mod_led
);

    // number of failed assertions so far
    int fail_count = 0;

    // exactly one digit enabled at a time
    property one_digit_low;
        @(posedge clk_64m) disable iff (rst) $onehot(~seg_s);
    endproperty

    // capture reports with a one-cycle pulse
    property single_cycle_report;
        @(posedge clk_64m) disable iff (rst) bins_valid |=> !bins_valid;
    endproperty

    // leds read unknown while in reset
    property led_clear_in_reset;
        @(posedge clk_64m) rst |=> mod_led == mod_unknown;
    endproperty

    assert property (one_digit_low)
        else begin
            fail_count++;
            $error("seg_s does not have exactly one low bit");
        end

    assert property (single_cycle_report)
        else begin
            fail_count++;
            $error("bins_valid stayed high for more than one cycle");
        end

    assert property (led_clear_in_reset)
        else begin
            fail_count++;
            $error("mod_led is not unknown during reset");
        end

endmodule

// bins_valid is internal to the top level
bind modulation_id_top modulation_id_sva modulation_id_sva_inst (
    .clk_64m    (clk_64m),
    .rst        (rst),
    .seg_s      (seg_s),
    .bins_valid (bins_valid),
    .mod_led    (mod_led)
);

/* verification/modulation_id_tb.sv */
`timescale 1ns/10ps

module modulation_id_tb import modulation_pkg::*; ();

    localparam int frame_len = 4096;
    localparam int frame_rows = 60;
    localparam int group_count = frame_rows / frames_per_decision;
    localparam int decision_timeout = 2 * frame_len;

    // real amplitudes of the peak and side bins
    localparam int pk_a = 134217728;
    localparam int pk_b = 200000000;
    localparam int sd_cw = 1048576;
    localparam int sd_am = 6000000;
    localparam int sd_fm = 33554432;
    // upper half bin that would win the peak search if stored
    localparam int decoy_amp = 268435455;

    logic                      clk_64m = 1'b0;
    logic                      rst;
    logic signed [fft_w-1:0]   fft_real;
    logic signed [fft_w-1:0]   fft_imag;
    logic        [index_w-1:0] fft_index;
    logic        [mod_w-1:0]   mod_led;
    logic [digit_count-1:0]    seg_s;
    logic [7:0]                seg_ap;

    logic [31:0] lcg_state;
    int          cycle_count;

    // one row per frame and ten rows per decision
    // groups in order cw, tie 2/4/4, am, fm, mixed 4/3/3 and edge bins
    // stale tallies after the cw group would turn the tie group into cw
    int row_bin [frame_rows] = '{
        100, 500, 1000, 1500, 37, 812, 1999, 256, 640, 1234,
        55, 1010, 1700, 400, 1290, 222, 1950, 600, 1530, 30,
        77, 333, 901, 1777, 12, 1024, 2000, 450, 1300, 64,
        210, 999, 1600, 45, 720, 1111, 1888, 8, 512, 1450,
        300, 700, 1200, 1900, 20, 880, 1420, 160, 1650, 95,
        2047, 2046, 2, 3, 2045, 4, 2040, 5, 2047, 2
    };
    int row_peak [frame_rows] = '{
        pk_a, pk_b, pk_a, pk_b, pk_a, pk_b, pk_a, pk_b, pk_a, pk_b,
        pk_a, pk_b, pk_b, pk_a, pk_a, pk_b, pk_a, pk_b, pk_b, pk_a,
        pk_b, pk_a, pk_b, pk_a, pk_b, pk_a, pk_b, pk_a, pk_b, pk_a,
        pk_a, pk_a, pk_b, pk_b, pk_a, pk_a, pk_b, pk_b, pk_a, pk_b,
        pk_b, pk_a, pk_a, pk_b, pk_a, pk_b, pk_b, pk_a, pk_a, pk_b,
        pk_b, pk_a, pk_b, pk_a, pk_b, pk_a, pk_b, pk_a, pk_a, pk_b
    };
    int row_side [frame_rows] = '{
        sd_cw, sd_cw, sd_cw, sd_cw, sd_cw, sd_cw, sd_cw, sd_cw, sd_cw, sd_cw,
        sd_am, sd_fm, sd_cw, sd_am, sd_fm, sd_fm, sd_am, sd_cw, sd_am, sd_fm,
        sd_am, sd_am, sd_am, sd_am, sd_am, sd_am, sd_am, sd_am, sd_am, sd_am,
        sd_fm, sd_fm, sd_fm, sd_fm, sd_fm, sd_fm, sd_fm, sd_fm, sd_fm, sd_fm,
        sd_cw, sd_am, sd_fm, sd_cw, sd_am, sd_cw, sd_fm, sd_am, sd_fm, sd_cw,
        sd_cw, sd_am, sd_am, sd_am, sd_fm, sd_am, sd_cw, sd_fm, sd_am, sd_am
    };

    modulation_id_top modulation_id_top_inst (
        .clk_64m   (clk_64m),
        .rst       (rst),
        .fft_real  (fft_real),
        .fft_imag  (fft_imag),
        .fft_index (fft_index),
        .mod_led   (mod_led),
        .seg_s     (seg_s),
        .seg_ap    (seg_ap)
    );

    // 50 MHz stand-in for the 64 MHz board clock
    always #10 clk_64m = ~clk_64m;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // top 32 of the 60 power bits as buffered
    function automatic logic [stored_w-1:0] stored_slice(input longint amp);
        logic [power_w-1:0] full;
        full = power_w'(amp * amp);
        return full[power_w-1:power_w-stored_w];
    endfunction

    function automatic logic [mod_w-1:0] expected_vote(input int peak_amp, input int side_amp);
        logic [stored_w-1:0] centre;
        logic [stored_w-1:0] side;
        centre = stored_slice(peak_amp);
        side = stored_slice(side_amp);
        if ((centre >> cw_shift) > side) begin
            return mod_cw;
        end else if ((centre >> am_shift) > side) begin
            return mod_am;
        end
        return mod_fm;
    endfunction

    // ties go to fm
    function automatic logic [mod_w-1:0] majority_of(input int n_cw, input int n_am,
                                                     input int n_fm);
        if (n_cw > n_am) begin
            return (n_cw > n_fm) ? mod_cw : mod_fm;
        end
        return (n_am > n_fm) ? mod_am : mod_fm;
    endfunction

    // active-low words for 0, C, A and F
    function automatic logic [7:0] digit_word(input logic [mod_w-1:0] mod);
        case (mod)
            mod_cw:  return 8'hC6;
            mod_am:  return 8'h88;
            mod_fm:  return 8'h8E;
            default: return 8'hC0;
        endcase
    endfunction

    function automatic logic [digit_count-1:0] scan_word(input int n);
        logic [digit_count-1:0] w;
        w = '1;
        w[n % digit_count] = 1'b0;
        return w;
    endfunction

    task automatic fail_stop(input string line);
        $display("%s", line);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_mod(input logic [mod_w-1:0] got, input logic [mod_w-1:0] exp,
                             input string what);
        if (got !== exp) begin
            fail_stop($sformatf("** Error at %0t: %s mod_led is %0d, expected %0d",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_seg_ap(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            fail_stop($sformatf("** Error at %0t: %s seg_ap is %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_seg_s(input logic [digit_count-1:0] got,
                               input logic [digit_count-1:0] exp, input string what);
        if (got !== exp) begin
            fail_stop($sformatf("** Error at %0t: %s seg_s is %b, expected %b",
                                $time, what, got, exp));
        end
    endtask

    // watch the bound checker
    always @(modulation_id_top_inst.modulation_id_sva_inst.fail_count) begin
        if (modulation_id_top_inst.modulation_id_sva_inst.fail_count != 0) begin
            fail_stop("a bound assertion on the display or decision outputs failed");
        end
    end

    // inputs move 2 ns after the edge
    task automatic step();
        @(posedge clk_64m);
        #2;
        cycle_count++;
    endtask

    // indices 0 to 4095 with noise everywhere except peak, side and decoy
    task automatic play_frame(input int row);
        logic [31:0]             r;
        logic signed [fft_w-1:0] re;
        logic signed [fft_w-1:0] im;
        for (int idx = 0; idx < frame_len; idx++) begin
            step();
            r = lcg_next();
            re = fft_w'($signed(r[31:21]));
            im = fft_w'($signed(r[15:5]));
            if (idx == row_bin[row]) begin
                re = fft_w'(row_peak[row]);
                im = '0;
            end else if (idx == row_bin[row] - 2) begin
                re = fft_w'(row_side[row]);
                im = '0;
            end else if (idx == row_bin[row] + bin_count) begin
                re = fft_w'(decoy_amp);
            end
            fft_index = index_w'(idx);
            fft_real = re;
            fft_imag = im;
        end
    endtask

    // the mod_led change marks the decision
    task automatic wait_for_decision(input logic [mod_w-1:0] prev);
        int waited;
        waited = 0;
        while (mod_led === prev) begin
            if (waited >= decision_timeout) begin
                fail_stop("timeout: mod_led did not change after the tenth frame of a group");
            end
            step();
            waited++;
        end
    endtask

    initial begin
        int               n_cw;
        int               n_am;
        int               n_fm;
        int               row;
        logic [mod_w-1:0] vote;
        logic [mod_w-1:0] expected;
        logic [mod_w-1:0] shown;
        lcg_state = 32'h688c4213;
        cycle_count = 0;
        rst = 1'b1;
        fft_real = '0;
        fft_imag = '0;
        fft_index = '0;
        repeat (10) @(posedge clk_64m);
        #2;
        rst = 1'b0;
        cycle_count = 0;

        // reset state shows 0 with a walking digit select
        for (int k = 0; k < 8; k++) begin
            check_mod(mod_led, mod_unknown, "after reset");
            check_seg_ap(seg_ap, digit_word(mod_unknown), "after reset");
            check_seg_s(seg_s, scan_word(cycle_count), "after reset");
            step();
        end

        shown = mod_unknown;
        for (int g = 0; g < group_count; g++) begin
            n_cw = 0;
            n_am = 0;
            n_fm = 0;
            for (int f = 0; f < frames_per_decision; f++) begin
                row = g * frames_per_decision + f;
                play_frame(row);
                vote = expected_vote(row_peak[row], row_side[row]);
                case (vote)
                    mod_cw:  n_cw++;
                    mod_am:  n_am++;
                    default: n_fm++;
                endcase
                // no decision before the tenth vote
                if (f < frames_per_decision - 1) begin
                    check_mod(mod_led, shown, "within group");
                end
            end
            expected = majority_of(n_cw, n_am, n_fm);
            wait_for_decision(shown);
            check_mod(mod_led, expected, "decision");
            check_seg_ap(seg_ap, digit_word(expected), "decision");
            check_seg_s(seg_s, scan_word(cycle_count), "decision");
            shown = expected;
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* files.f */
design/modulation_pkg.sv
design/power_calc.sv
design/spectrum_capture.sv
design/modulation_vote.sv
design/seg7_scan.sv
design/modulation_id_top.sv
verification/modulation_id_sva.sv
verification/modulation_id_tb.sv

/* Bender.yml */
package:
  name: modulation_id

sources:
  - design/modulation_pkg.sv
  - design/power_calc.sv
  - design/spectrum_capture.sv
  - design/modulation_vote.sv
  - design/seg7_scan.sv
  - design/modulation_id_top.sv
  - target: simulation
    files:
      - verification/modulation_id_sva.sv
      - verification/modulation_id_tb.sv
